// ==== hdl/controlDecoder.sv ====
`timescale 1ns/1ps

module controlDecoder (
	input  isaPkg::opcodeE            opcode,
	input  logic [isaPkg::functW-1:0] funct,
	output isaPkg::regDstE            regDst,
	output isaPkg::extSelE            extSel,
	output logic                      regWrite,
	output logic                      memEn,
	output logic                      memWrite,
	output logic                      memToReg,
	output logic                      memDump,
	output logic                      aluSrc2,
	output logic                      pcSrc,
	output logic                      pcImm,
	output logic                      jump,
	output logic                      writeDataSel,
	output logic                      haltN,
	output isaPkg::aluOpE             aluCtrl,
	output logic [1:0]                opLow
);

	always_comb begin
		// Defaults describe a NOP
		regDst = isaPkg::RD_LOW;
		extSel = isaPkg::ZERO5;
		regWrite = 1'b0;
		memEn = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		memDump = 1'b0;
		aluSrc2 = 1'b0;
		pcSrc = 1'b0;
		pcImm = 1'b0;
		jump = 1'b0;
		writeDataSel = 1'b0;
		haltN = 1'b1;
		aluCtrl = isaPkg::PASS;
		// Branch condition and memory variants come from the opcode tail
		opLow = opcode[1:0];

		case (opcode)
			isaPkg::HALT: begin
				haltN = 1'b0;
				memDump = 1'b1;
			end
			isaPkg::ADDI, isaPkg::SUBI, isaPkg::XORI, isaPkg::ANDNI: begin
				regDst = isaPkg::RD_MID;
				regWrite = 1'b1;
				aluSrc2 = 1'b1;
				// Only add and subtract take a signed immediate
				extSel = opcode[1] ? isaPkg::ZERO5 : isaPkg::SIGN5;
				aluCtrl = isaPkg::aluOpE'({2'b00, opcode[1:0]});
			end
			isaPkg::ROLI, isaPkg::SLLI, isaPkg::RORI, isaPkg::SRLI: begin
				regDst = isaPkg::RD_MID;
				regWrite = 1'b1;
				aluSrc2 = 1'b1;
				aluCtrl = isaPkg::aluOpE'({2'b01, opcode[1:0]});
			end
			isaPkg::ST, isaPkg::LD, isaPkg::STU: begin
				extSel = isaPkg::SIGN5;
				memEn = 1'b1;
				aluSrc2 = 1'b1;
				aluCtrl = isaPkg::ADD;
				memWrite = (opcode != isaPkg::LD);
				memToReg = (opcode == isaPkg::LD);
				regWrite = (opcode != isaPkg::ST);
				// STU writes the updated address back into rs
				regDst = (opcode == isaPkg::STU) ? isaPkg::RD_HIGH : isaPkg::RD_MID;
			end
			isaPkg::BTR: begin
				regWrite = 1'b1;
				aluCtrl = isaPkg::BTR_OP;
			end
			isaPkg::ALUR: begin
				regWrite = 1'b1;
				aluCtrl = isaPkg::aluOpE'({2'b00, funct});
			end
			isaPkg::SHIFTR: begin
				regWrite = 1'b1;
				aluCtrl = isaPkg::aluOpE'({2'b01, funct});
			end
			isaPkg::SEQ, isaPkg::SLT, isaPkg::SLE, isaPkg::SCO: begin
				regWrite = 1'b1;
				aluCtrl = isaPkg::aluOpE'({2'b10, opcode[1:0]});
			end
			isaPkg::BEQZ, isaPkg::BNEZ, isaPkg::BLTZ, isaPkg::BGEZ: begin
				extSel = isaPkg::SIGN8;
				pcSrc = 1'b1;
				pcImm = 1'b1;
			end
			isaPkg::LBI, isaPkg::SLBI: begin
				regDst = isaPkg::RD_HIGH;
				regWrite = 1'b1;
				aluSrc2 = 1'b1;
				extSel = (opcode == isaPkg::LBI) ? isaPkg::SIGN8 : isaPkg::ZERO8;
				aluCtrl = (opcode == isaPkg::LBI) ? isaPkg::LBI_OP : isaPkg::SLBI_OP;
			end
			isaPkg::J, isaPkg::JAL: begin
				extSel = isaPkg::SIGN11;
				pcImm = 1'b1;
				jump = 1'b1;
				if (opcode == isaPkg::JAL) begin
					regDst = isaPkg::RD_LINK;
					regWrite = 1'b1;
					writeDataSel = 1'b1;
				end
			end
			isaPkg::JR, isaPkg::JALR: begin
				// Target is rs plus the immediate, computed by the ALU
				extSel = isaPkg::SIGN8;
				aluSrc2 = 1'b1;
				aluCtrl = isaPkg::ADD;
				jump = 1'b1;
				if (opcode == isaPkg::JALR) begin
					regDst = isaPkg::RD_LINK;
					regWrite = 1'b1;
					writeDataSel = 1'b1;
				end
			end
			default: begin
				// NOP and unknown opcodes keep the defaults
				haltN = 1'b1;
			end
		endcase
	end

endmodule

// ==== hdl/decodeTop.sv ====
`timescale 1ns/1ps

module decodeTop (
	input  logic                       clk,
	input  logic                       arstN,
	input  logic [isaPkg::dataW-1:0]   inst,
	input  logic [isaPkg::regSelW-1:0] wbRegSel,
	input  logic [isaPkg::dataW-1:0]   wbData,
	input  logic                       wbEn,
	output logic                       stall,
	output logic                       exRegWrite,
	output logic                       exMemEn,
	output logic                       exMemWrite,
	output logic                       exMemToReg,
	output logic                       exMemDump,
	output logic                       exAluSrc2,
	output logic                       exPcSrc,
	output logic                       exPcImm,
	output logic                       exJump,
	output logic                       exWriteDataSel,
	output logic                       exHaltN,
	output isaPkg::aluOpE              exAluCtrl,
	output logic [1:0]                 exOpLow,
	output logic [isaPkg::regSelW-1:0] exWriteRegSel,
	output logic [isaPkg::dataW-1:0]   exReadData1,
	output logic [isaPkg::dataW-1:0]   exReadData2,
	output logic [isaPkg::dataW-1:0]   exImm,
	output logic [isaPkg::regSelW-1:0] exRs,
	output logic [isaPkg::regSelW-1:0] exRt
);

	logic regWrite, memEn, memWrite, memToReg, memDump, aluSrc2;
	logic pcSrc, pcImm, jump, writeDataSel, haltN;
	isaPkg::aluOpE aluCtrl;
	logic [1:0] opLow;
	logic [isaPkg::regSelW-1:0] writeRegSel, rs, rt;
	logic [isaPkg::dataW-1:0] readData1, readData2, imm;

	// ID/EX destination and load flags close the hazard loop
	idStage stage0 (
		.clk(clk), .arstN(arstN), .inst(inst),
		.wbRegSel(wbRegSel), .wbData(wbData), .wbEn(wbEn),
		.exRegWrite(exRegWrite), .exWriteRegSel(exWriteRegSel),
		.exMemEn(exMemEn), .exMemWrite(exMemWrite), .hazard(stall),
		.regWrite(regWrite), .memEn(memEn), .memWrite(memWrite),
		.memToReg(memToReg), .memDump(memDump), .aluSrc2(aluSrc2),
		.pcSrc(pcSrc), .pcImm(pcImm), .jump(jump), .writeDataSel(writeDataSel),
		.haltN(haltN), .aluCtrl(aluCtrl), .opLow(opLow), .writeRegSel(writeRegSel),
		.readData1(readData1), .readData2(readData2), .imm(imm), .rs(rs), .rt(rt)
	);

	idExReg idEx0 (
		.clk(clk), .arstN(arstN),
		.regWrite(regWrite), .memEn(memEn), .memWrite(memWrite),
		.memToReg(memToReg), .memDump(memDump), .aluSrc2(aluSrc2),
		.pcSrc(pcSrc), .pcImm(pcImm), .jump(jump), .writeDataSel(writeDataSel),
		.haltN(haltN), .aluCtrl(aluCtrl), .opLow(opLow), .writeRegSel(writeRegSel),
		.readData1(readData1), .readData2(readData2), .imm(imm), .rs(rs), .rt(rt),
		.exRegWrite(exRegWrite), .exMemEn(exMemEn), .exMemWrite(exMemWrite),
		.exMemToReg(exMemToReg), .exMemDump(exMemDump), .exAluSrc2(exAluSrc2),
		.exPcSrc(exPcSrc), .exPcImm(exPcImm), .exJump(exJump),
		.exWriteDataSel(exWriteDataSel), .exHaltN(exHaltN), .exAluCtrl(exAluCtrl),
		.exOpLow(exOpLow), .exWriteRegSel(exWriteRegSel),
		.exReadData1(exReadData1), .exReadData2(exReadData2), .exImm(exImm),
		.exRs(exRs), .exRt(exRt)
	);

endmodule

// ==== hdl/idExReg.sv ====
`timescale 1ns/1ps

module idExReg (
	input  logic                       clk,
	input  logic                       arstN,
	input  logic                       regWrite,
	input  logic                       memEn,
	input  logic                       memWrite,
	input  logic                       memToReg,
	input  logic                       memDump,
	input  logic                       aluSrc2,
	input  logic                       pcSrc,
	input  logic                       pcImm,
	input  logic                       jump,
	input  logic                       writeDataSel,
	input  logic                       haltN,
	input  isaPkg::aluOpE              aluCtrl,
	input  logic [1:0]                 opLow,
	input  logic [isaPkg::regSelW-1:0] writeRegSel,
	input  logic [isaPkg::dataW-1:0]   readData1,
	input  logic [isaPkg::dataW-1:0]   readData2,
	input  logic [isaPkg::dataW-1:0]   imm,
	input  logic [isaPkg::regSelW-1:0] rs,
	input  logic [isaPkg::regSelW-1:0] rt,
	output logic                       exRegWrite,
	output logic                       exMemEn,
	output logic                       exMemWrite,
	output logic                       exMemToReg,
	output logic                       exMemDump,
	output logic                       exAluSrc2,
	output logic                       exPcSrc,
	output logic                       exPcImm,
	output logic                       exJump,
	output logic                       exWriteDataSel,
	output logic                       exHaltN,
	output isaPkg::aluOpE              exAluCtrl,
	output logic [1:0]                 exOpLow,
	output logic [isaPkg::regSelW-1:0] exWriteRegSel,
	output logic [isaPkg::dataW-1:0]   exReadData1,
	output logic [isaPkg::dataW-1:0]   exReadData2,
	output logic [isaPkg::dataW-1:0]   exImm,
	output logic [isaPkg::regSelW-1:0] exRs,
	output logic [isaPkg::regSelW-1:0] exRt
);

	// Loads every cycle, a stalled slot arrives here already zeroed
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			{exRegWrite, exMemEn, exMemWrite, exMemToReg, exMemDump} <= '0;
			{exAluSrc2, exPcSrc, exPcImm, exJump, exWriteDataSel} <= '0;
			exHaltN <= 1'b1;
			exAluCtrl <= isaPkg::ADD;
			exOpLow <= '0;
			exWriteRegSel <= '0;
			{exReadData1, exReadData2, exImm} <= '0;
			{exRs, exRt} <= '0;
		end else begin
			{exRegWrite, exMemEn, exMemWrite} <= {regWrite, memEn, memWrite};
			{exMemToReg, exMemDump, exAluSrc2} <= {memToReg, memDump, aluSrc2};
			{exPcSrc, exPcImm, exJump} <= {pcSrc, pcImm, jump};
			exWriteDataSel <= writeDataSel;
			exHaltN <= haltN;
			exAluCtrl <= aluCtrl;
			exOpLow <= opLow;
			exWriteRegSel <= writeRegSel;
			{exReadData1, exReadData2, exImm} <= {readData1, readData2, imm};
			{exRs, exRt} <= {rs, rt};
		end
	end

endmodule

// ==== hdl/idStage.sv ====
`timescale 1ns/1ps

module idStage (
	input  logic                       clk,
	input  logic                       arstN,
	input  logic [isaPkg::dataW-1:0]   inst,
	input  logic [isaPkg::regSelW-1:0] wbRegSel,
	input  logic [isaPkg::dataW-1:0]   wbData,
	input  logic                       wbEn,
	input  logic                       exRegWrite,
	input  logic [isaPkg::regSelW-1:0] exWriteRegSel,
	input  logic                       exMemEn,
	input  logic                       exMemWrite,
	output logic                       hazard,
	output logic                       regWrite,
	output logic                       memEn,
	output logic                       memWrite,
	output logic                       memToReg,
	output logic                       memDump,
	output logic                       aluSrc2,
	output logic                       pcSrc,
	output logic                       pcImm,
	output logic                       jump,
	output logic                       writeDataSel,
	output logic                       haltN,
	output isaPkg::aluOpE              aluCtrl,
	output logic [1:0]                 opLow,
	output logic [isaPkg::regSelW-1:0] writeRegSel,
	output logic [isaPkg::dataW-1:0]   readData1,
	output logic [isaPkg::dataW-1:0]   readData2,
	output logic [isaPkg::dataW-1:0]   imm,
	output logic [isaPkg::regSelW-1:0] rs,
	output logic [isaPkg::regSelW-1:0] rt
);

	isaPkg::regDstE regDst;
	isaPkg::extSelE extSel;
	logic regWriteRaw, memEnRaw, memWriteRaw, memDumpRaw;
	logic pcSrcRaw, pcImmRaw, jumpRaw;
	logic loadInEx;

	controlDecoder ctrl0 (
		.opcode(isaPkg::opcodeE'(inst[15:11])), .funct(inst[1:0]),
		.regDst(regDst), .extSel(extSel), .regWrite(regWriteRaw),
		.memEn(memEnRaw), .memWrite(memWriteRaw), .memToReg(memToReg),
		.memDump(memDumpRaw), .aluSrc2(aluSrc2), .pcSrc(pcSrcRaw),
		.pcImm(pcImmRaw), .jump(jumpRaw), .writeDataSel(writeDataSel),
		.haltN(haltN), .aluCtrl(aluCtrl), .opLow(opLow)
	);

	regFileBypass regFile0 (
		.clk(clk), .arstN(arstN), .readSel1(rs), .readSel2(rt),
		.writeSel(wbRegSel), .writeData(wbData), .writeEn(wbEn),
		.readData1(readData1), .readData2(readData2)
	);

	immExtend ext0 (.field(inst[10:0]), .extSel(extSel), .imm(imm));

	assign rs = inst[10:8];
	assign rt = inst[7:5];

	always_comb begin
		case (regDst)
			isaPkg::RD_LOW:  writeRegSel = inst[4:2];
			isaPkg::RD_MID:  writeRegSel = inst[7:5];
			isaPkg::RD_HIGH: writeRegSel = inst[10:8];
			default:         writeRegSel = isaPkg::linkReg;
		endcase
	end

	// Load in ID/EX whose result this instruction needs
	assign loadInEx = exMemEn && !exMemWrite && exRegWrite;
	assign hazard = loadInEx && ((rs == exWriteRegSel) || (rt == exWriteRegSel));

	// Bubble: nothing that changes state may leave this stage
	assign regWrite = regWriteRaw && !hazard;
	assign memEn = memEnRaw && !hazard;
	assign memWrite = memWriteRaw && !hazard;
	assign memDump = memDumpRaw && !hazard;
	assign pcSrc = pcSrcRaw && !hazard;
	assign pcImm = pcImmRaw && !hazard;
	assign jump = jumpRaw && !hazard;

endmodule

// ==== hdl/immExtend.sv ====
`timescale 1ns/1ps

module immExtend (
	input  logic [isaPkg::immFieldW-1:0] field,
	input  isaPkg::extSelE               extSel,
	output logic [isaPkg::dataW-1:0]     imm
);

	localparam int dW = isaPkg::dataW;

	always_comb begin
		case (extSel)
			isaPkg::ZERO5:  imm = {{(dW - 5){1'b0}}, field[4:0]};
			isaPkg::ZERO8:  imm = {{(dW - 8){1'b0}}, field[7:0]};
			isaPkg::SIGN5:  imm = {{(dW - 5){field[4]}}, field[4:0]};
			isaPkg::SIGN8:  imm = {{(dW - 8){field[7]}}, field[7:0]};
			isaPkg::SIGN11: imm = {{(dW - 11){field[10]}}, field[10:0]};
			// Unused selects
			default:        imm = '0;
		endcase
	end

endmodule

// ==== hdl/isaPkg.sv ====
package isaPkg;

	// Datapath widths
	localparam int dataW = 16;
	localparam int regSelW = 3;
	localparam int numRegs = 1 << regSelW;
	localparam int opcodeW = 5;
	localparam int functW = 2;
	localparam int immFieldW = 11;
	localparam int aluOpW = 4;
	localparam int extSelW = 3;
	localparam int regDstW = 2;

	// JAL and JALR write the return address here
	localparam logic [regSelW-1:0] linkReg = 3'd7;

	// Instruction opcodes, bits 15..11
	typedef enum logic [opcodeW-1:0] {
		HALT   = 5'b00000,
		NOP    = 5'b00001,
		J      = 5'b00100,
		JR     = 5'b00101,
		JAL    = 5'b00110,
		JALR   = 5'b00111,
		ADDI   = 5'b01000,
		SUBI   = 5'b01001,
		XORI   = 5'b01010,
		ANDNI  = 5'b01011,
		BEQZ   = 5'b01100,
		BNEZ   = 5'b01101,
		BLTZ   = 5'b01110,
		BGEZ   = 5'b01111,
		ST     = 5'b10000,
		LD     = 5'b10001,
		SLBI   = 5'b10010,
		STU    = 5'b10011,
		ROLI   = 5'b10100,
		SLLI   = 5'b10101,
		RORI   = 5'b10110,
		SRLI   = 5'b10111,
		LBI    = 5'b11000,
		BTR    = 5'b11001,
		SHIFTR = 5'b11010,
		ALUR   = 5'b11011,
		SEQ    = 5'b11100,
		SLT    = 5'b11101,
		SLE    = 5'b11110,
		SCO    = 5'b11111
	} opcodeE;

	// ALU operations; low two bits line up with opcode and funct bits
	typedef enum logic [aluOpW-1:0] {
		ADD, SUB, XOR, ANDN,
		ROL, SLL, ROR, SRL,
		SEQ_OP, SLT_OP, SLE_OP, SCO_OP,
		BTR_OP, LBI_OP, SLBI_OP, PASS
	} aluOpE;

	// Immediate extension select
	typedef enum logic [extSelW-1:0] {
		ZERO5  = 3'd0,
		ZERO8  = 3'd1,
		SIGN5  = 3'd2,
		SIGN8  = 3'd4,
		SIGN11 = 3'd6
	} extSelE;

	// Destination register source
	typedef enum logic [regDstW-1:0] {
		RD_LOW  = 2'd0,
		RD_MID  = 2'd1,
		RD_HIGH = 2'd2,
		RD_LINK = 2'd3
	} regDstE;

endpackage

// ==== hdl/regFileBypass.sv ====
`timescale 1ns/1ps

module regFileBypass (
	input  logic                       clk,
	input  logic                       arstN,
	input  logic [isaPkg::regSelW-1:0] readSel1,
	input  logic [isaPkg::regSelW-1:0] readSel2,
	input  logic [isaPkg::regSelW-1:0] writeSel,
	input  logic [isaPkg::dataW-1:0]   writeData,
	input  logic                       writeEn,
	output logic [isaPkg::dataW-1:0]   readData1,
	output logic [isaPkg::dataW-1:0]   readData2
);

	logic [isaPkg::dataW-1:0] regs [isaPkg::numRegs];
	logic                     bypass1;
	logic                     bypass2;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < isaPkg::numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeSel] <= writeData;
		end
	end

	// Same-cycle write wins over the stored value
	assign bypass1 = writeEn && (writeSel == readSel1);
	assign bypass2 = writeEn && (writeSel == readSel2);

	assign readData1 = bypass1 ? writeData : regs[readSel1];
	assign readData2 = bypass2 ? writeData : regs[readSel2];

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module decodeTb -f src.f -o simv > build.log 2>&1 \
	&& ./obj_dir/simv > sim.log 2>&1 \
	|| echo "Build or simulation did not complete"
grep -q "All checks passed" sim.log 2>/dev/null \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
exit 0

// ==== src.f ====
+incdir+tb
hdl/isaPkg.sv
hdl/controlDecoder.sv
hdl/regFileBypass.sv
hdl/immExtend.sv
hdl/idStage.sv
hdl/idExReg.sv
hdl/decodeTop.sv
tb/decodeTb.sv

// ==== tb/decodeRef.svh ====
// Fibonacci LFSR, taps 32 22 2 1
logic [31:0] lfsrState = 32'h6be7;

function automatic logic [31:0] lfsrStep(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One LFSR step per bit taken, up to 16 bits
function automatic logic [15:0] randBits(input int n);
	logic [15:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		lfsrState = lfsrStep(lfsrState);
		r = {r[14:0], lfsrState[0]};
	end
	return r;
endfunction

// Expected ID outputs; ext codes 0 zero5, 1 zero8, 2 sign5, 3 sign8, 4 sign11
function automatic void decodeRef(input logic [15:0] ins, input logic [15:0] rf [8],
		input logic wEn, input logic [2:0] wSel, input logic [15:0] wData,
		input logic exLoad, input logic [2:0] exDst, output logic [10:0] ctl,
		output isaPkg::aluOpE alu, output logic [1:0] opl, output logic [2:0] wreg,
		output logic [15:0] rd1, output logic [15:0] rd2, output logic [15:0] immV,
		output logic hz);
	logic [4:0] op;
	logic [2:0] rsV, rtV;
	int ext;
	logic rw, mEn, mWr, mToR, dump, src2, pSrc, pImm, jmp, wds, hN;
	op = ins[15:11];
	rsV = ins[10:8];
	rtV = ins[7:5];
	{rw, mEn, mWr, mToR, dump, src2, pSrc, pImm, jmp, wds} = '0;
	hN = 1'b1;
	alu = isaPkg::PASS;
	opl = op[1:0];
	wreg = ins[4:2];
	ext = 0;
	case (op)
		isaPkg::HALT: begin
			hN = 1'b0;
			dump = 1'b1;
		end
		isaPkg::ADDI, isaPkg::SUBI, isaPkg::XORI, isaPkg::ANDNI: begin
			wreg = rtV;
			rw = 1'b1;
			src2 = 1'b1;
			ext = op[1] ? 0 : 2;
			alu = isaPkg::aluOpE'({2'b00, op[1:0]});
		end
		isaPkg::ROLI, isaPkg::SLLI, isaPkg::RORI, isaPkg::SRLI: begin
			wreg = rtV;
			rw = 1'b1;
			src2 = 1'b1;
			alu = isaPkg::aluOpE'({2'b01, op[1:0]});
		end
		isaPkg::ST, isaPkg::LD, isaPkg::STU: begin
			ext = 2;
			mEn = 1'b1;
			src2 = 1'b1;
			alu = isaPkg::ADD;
			mWr = (op != isaPkg::LD);
			mToR = (op == isaPkg::LD);
			rw = (op != isaPkg::ST);
			wreg = (op == isaPkg::STU) ? rsV : rtV;
		end
		isaPkg::BTR: begin
			rw = 1'b1;
			alu = isaPkg::BTR_OP;
		end
		isaPkg::ALUR, isaPkg::SHIFTR: begin
			rw = 1'b1;
			alu = isaPkg::aluOpE'({1'b0, op == isaPkg::SHIFTR, ins[1:0]});
		end
		isaPkg::SEQ, isaPkg::SLT, isaPkg::SLE, isaPkg::SCO: begin
			rw = 1'b1;
			alu = isaPkg::aluOpE'({2'b10, op[1:0]});
		end
		isaPkg::BEQZ, isaPkg::BNEZ, isaPkg::BLTZ, isaPkg::BGEZ: begin
			ext = 3;
			pSrc = 1'b1;
			pImm = 1'b1;
		end
		isaPkg::LBI, isaPkg::SLBI: begin
			wreg = rsV;
			rw = 1'b1;
			src2 = 1'b1;
			ext = (op == isaPkg::LBI) ? 3 : 1;
			alu = (op == isaPkg::LBI) ? isaPkg::LBI_OP : isaPkg::SLBI_OP;
		end
		isaPkg::J, isaPkg::JAL, isaPkg::JR, isaPkg::JALR: begin
			jmp = 1'b1;
			// Register-relative jumps add rs and an 8-bit offset in the ALU
			if (op[0]) begin
				ext = 3;
				src2 = 1'b1;
				alu = isaPkg::ADD;
			end else begin
				ext = 4;
				pImm = 1'b1;
			end
			if (op[1]) begin
				wreg = isaPkg::linkReg;
				rw = 1'b1;
				wds = 1'b1;
			end
		end
		default: begin
			hN = 1'b1;
		end
	endcase
	case (ext)
		0: immV = {11'b0, ins[4:0]};
		1: immV = {8'b0, ins[7:0]};
		2: immV = {{11{ins[4]}}, ins[4:0]};
		3: immV = {{8{ins[7]}}, ins[7:0]};
		default: immV = {{5{ins[10]}}, ins[10:0]};
	endcase
	hz = exLoad && ((rsV == exDst) || (rtV == exDst));
	if (hz) begin
		{rw, mEn, mWr, dump, pSrc, pImm, jmp} = '0;
	end
	rd1 = (wEn && wSel == rsV) ? wData : rf[rsV];
	rd2 = (wEn && wSel == rtV) ? wData : rf[rtV];
	ctl = {rw, mEn, mWr, mToR, dump, src2, pSrc, pImm, jmp, wds, hN};
endfunction

// ==== tb/decodeTb.sv ====
`timescale 1ns/1ps

module decodeTb;

	logic clk = 1'b0;
	logic arstN;
	logic [15:0] inst, wbData;
	logic [2:0] wbRegSel;
	logic wbEn, stall;
	logic exRegWrite, exMemEn, exMemWrite, exMemToReg, exMemDump, exAluSrc2;
	logic exPcSrc, exPcImm, exJump, exWriteDataSel, exHaltN;
	isaPkg::aluOpE exAluCtrl;
	logic [1:0] exOpLow;
	logic [2:0] exWriteRegSel, exRs, exRt;
	logic [15:0] exReadData1, exReadData2, exImm;

	// Expected ID/EX contents and the shadow register file
	logic [10:0] expCtl = 11'b1;
	isaPkg::aluOpE expAlu = isaPkg::ADD;
	logic [1:0] expOpLow = '0;
	logic [2:0] expWreg = '0, expRs = '0, expRt = '0;
	logic [15:0] expRd1 = '0, expRd2 = '0, expImm = '0;
	logic [15:0] shadow [8];
	int errCount = 0;
	int checkCount = 0;
	int edgeCount = 0;
	string ctlNames [11] = '{"exRegWrite", "exMemEn", "exMemWrite", "exMemToReg",
		"exMemDump", "exAluSrc2", "exPcSrc", "exPcImm", "exJump", "exWriteDataSel", "exHaltN"};

	`include "decodeRef.svh"

	decodeTop dut0 (.*);

	always #5 clk = ~clk;

	task automatic checkBit(input string name, input logic expV, input logic actV);
		checkCount++;
		if (actV !== expV) begin
			errCount++;
			$display("** Error %s: expected %h, got %h at %0t", name, expV, actV, $time);
		end
	endtask

	task automatic checkAluOp(input string name, input isaPkg::aluOpE expV,
			input isaPkg::aluOpE actV);
		checkCount++;
		if (actV !== expV) begin
			errCount++;
			$display("** Error %s: expected %h, got %h at %0t", name, expV, actV, $time);
		end
	endtask

	task automatic checkReg(input string name, input logic [2:0] expV, input logic [2:0] actV);
		checkCount++;
		if (actV !== expV) begin
			errCount++;
			$display("** Error %s: expected %h, got %h at %0t", name, expV, actV, $time);
		end
	endtask

	task automatic checkData(input string name, input logic [15:0] expV,
			input logic [15:0] actV);
		checkCount++;
		if (actV !== expV) begin
			errCount++;
			$display("** Error %s: expected %h, got %h at %0t", name, expV, actV, $time);
		end
	endtask

	// Samples pre-edge values, so stimulus written at this edge is not seen yet
	always @(posedge clk) begin
		logic [10:0] actCtl;
		logic [10:0] nCtl;
		isaPkg::aluOpE nAlu;
		logic [1:0] nOpLow;
		logic [2:0] nWreg;
		logic [15:0] nRd1, nRd2, nImm;
		logic nHaz;
		edgeCount++;
		actCtl = {exRegWrite, exMemEn, exMemWrite, exMemToReg, exMemDump, exAluSrc2,
			exPcSrc, exPcImm, exJump, exWriteDataSel, exHaltN};
		for (int i = 0; i < 11; i++) begin
			checkBit(ctlNames[i], expCtl[10 - i], actCtl[10 - i]);
		end
		checkAluOp("exAluCtrl", expAlu, exAluCtrl);
		checkReg("exOpLow", {1'b0, expOpLow}, {1'b0, exOpLow});
		checkReg("exWriteRegSel", expWreg, exWriteRegSel);
		checkReg("exRs", expRs, exRs);
		checkReg("exRt", expRt, exRt);
		checkData("exReadData1", expRd1, exReadData1);
		checkData("exReadData2", expRd2, exReadData2);
		checkData("exImm", expImm, exImm);
		if (!arstN) begin
			checkBit("stall", 1'b0, stall);
			expCtl = 11'b1;
			expAlu = isaPkg::ADD;
			{expOpLow, expWreg, expRs, expRt, expRd1, expRd2, expImm} = '0;
			for (int i = 0; i < 8; i++) begin
				shadow[i] = '0;
			end
		end else begin
			decodeRef(inst, shadow, wbEn, wbRegSel, wbData, expCtl[9] && !expCtl[8],
				expWreg, nCtl, nAlu, nOpLow, nWreg, nRd1, nRd2, nImm, nHaz);
			checkBit("stall", nHaz, stall);
			{expCtl, expOpLow, expWreg} = {nCtl, nOpLow, nWreg};
			expAlu = nAlu;
			{expRd1, expRd2, expImm} = {nRd1, nRd2, nImm};
			{expRs, expRt} = {inst[10:8], inst[7:5]};
			if (wbEn) begin
				shadow[wbRegSel] = wbData;
			end
		end
	end

	task automatic drive(input logic [15:0] i, input logic we, input logic [2:0] ws,
			input logic [15:0] wd);
		@(posedge clk);
		inst <= i;
		wbEn <= we;
		wbRegSel <= ws;
		wbData <= wd;
	endtask

	task automatic reportTest(input string name, input int startErr);
		$display("Test %s finished with %0d errors", name, errCount - startErr);
	endtask

	// Drives a producer then a reader and counts the cycles the reader is held
	task automatic loadUse(input logic [4:0] first, input logic [2:0] r, input logic useRt,
			input int expStalls);
		int stalls;
		int n;
		stalls = 0;
		n = 0;
		drive({first, 3'd1, r, 5'd4}, 1'b0, 3'd0, 16'h0);
		drive({isaPkg::ALUR, useRt ? ~r : r, useRt ? r : ~r, 5'd0}, 1'b0, 3'd0, 16'h0);
		do begin
			@(posedge clk);
			n++;
			if (stall) begin
				stalls++;
			end
		end while (stall && n < 8);
		if (n >= 8) begin
			errCount++;
			$display("Stall did not clear within 8 cycles for register %0d", r);
		end else if (stalls != expStalls) begin
			errCount++;
			$display("Stall lasted %0d cycles for register %0d, expected %0d", stalls, r,
				expStalls);
		end
	endtask

	initial begin
		int startErr;
		int issued;
		int tries;
		logic [15:0] r;
		arstN = 1'b1;
		inst = {isaPkg::NOP, 11'd0};
		wbEn = 1'b0;
		wbRegSel = '0;
		wbData = '0;
		startErr = errCount;
		// A real falling edge resets the DUT before the first clock edge
		#1;
		arstN = 1'b0;
		repeat (3) @(posedge clk);
		arstN <= 1'b1;
		drive({isaPkg::NOP, 11'd0}, 1'b0, 3'd0, 16'h0);
		reportTest("reset", startErr);

		startErr = errCount;
		for (int op = 0; op < 32; op++) begin
			for (int f = 0; f < 4; f++) begin
				r = randBits(9);
				drive({5'(op), r[8:0], 2'(f)}, 1'b0, 3'd0, 16'h0);
			end
		end
		reportTest("decode", startErr);

		startErr = errCount;
		for (int i = 0; i < 8; i++) begin
			r = randBits(13);
			drive({isaPkg::ALUR, 3'(i), 3'(i), 5'd0}, 1'b1, 3'(i), {r[12:0], 3'(i)});
		end
		for (int i = 0; i < 8; i++) begin
			drive({isaPkg::ALUR, 3'(i), 3'(i + 1), 5'd0}, 1'b0, 3'd0, 16'h0);
		end
		reportTest("register file", startErr);

		startErr = errCount;
		for (int i = 0; i < 8; i += 3) begin
			loadUse(isaPkg::LD, 3'(i), 1'b0, 1);
			loadUse(isaPkg::LD, 3'(i), 1'b1, 1);
			loadUse(isaPkg::ST, 3'(i), 1'b1, 0);
		end
		reportTest("load-use", startErr);

		startErr = errCount;
		issued = 0;
		tries = 0;
		while (issued < 300 && tries < 1000) begin
			@(posedge clk);
			tries++;
			// The reader stays in IF/ID while stalled
			if (!stall) begin
				inst <= randBits(16);
				issued++;
			end
			wbEn <= randBits(1) == 16'd1;
			r = randBits(3);
			wbRegSel <= r[2:0];
			wbData <= randBits(16);
		end
		if (issued < 300) begin
			errCount++;
			$display("Random stream issued only %0d instructions", issued);
		end
		drive({isaPkg::NOP, 11'd0}, 1'b0, 3'd0, 16'h0);
		drive({isaPkg::NOP, 11'd0}, 1'b0, 3'd0, 16'h0);
		@(posedge clk);
		reportTest("random stream", startErr);

		$display("Checks run: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// Stops a run whose clock stalls or that runs too long
	initial begin
		int lastEdges;
		int ticks;
		logic stuck;
		lastEdges = 0;
		ticks = 0;
		stuck = 1'b0;
		while (!stuck && ticks < 300) begin
			#100;
			stuck = (edgeCount == lastEdges);
			lastEdges = edgeCount;
			ticks++;
		end
		if (stuck) begin
			$display("No clock edge seen within 100 ns");
		end else begin
			$display("Simulation ran past its time limit");
		end
		$display("Checks failed");
		$finish;
	end

endmodule
